// ==== files.f ====
source/sdPkg.sv
source/sdLinkIf.sv
source/crc7.sv
source/sdClockGen.sv
source/cmdSender.sv
source/respReceiver.sv
source/hostSequencer.sv
source/sdCmdHost.sv
testbench/tbClock.sv
testbench/tbSdCmdHost.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tbSdCmdHost -f files.f -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

// ==== source/cmdSender.sv ====
`timescale 1ns/1ps

module cmdSender (
    input  logic        clk_fast,
    input  logic        rst,
    input  logic        fallTick,
    output logic        cmdOut,
    output logic        cmdOutEn,
    sdLinkIf.sender     link
);

    sdPkg::sendStateT state;
    sdPkg::bitCntT bitCnt;
    logic [sdPkg::CmdFrameBits-1:0] shiftReg;
    logic crcClear;
    logic crcEnable;
    logic crcShiftOut;
    logic crcMsb;

    assign link.sendBusy = cmdOutEn;

    assign crcClear = (state == sdPkg::SendIdle) && link.sendStart;
    assign crcEnable = fallTick && ((state == sdPkg::SendCmd) || (state == sdPkg::SendCrc));
    assign crcShiftOut = (state == sdPkg::SendCrc);

    // ======================================================================
    // Frame FSM, one bit per fallTick
    // ======================================================================
    always_ff @(posedge clk_fast) begin
        if (rst) begin
            state <= sdPkg::SendIdle;
            bitCnt <= '0;
            cmdOut <= 1'b1;
            cmdOutEn <= 1'b0;
            link.sendDone <= 1'b0;
        end else begin
            link.sendDone <= 1'b0;
            case (state)
                sdPkg::SendIdle: begin
                    if (link.sendStart) begin
                        bitCnt <= '0;
                        state <= sdPkg::SendCmd;
                    end
                end
                sdPkg::SendCmd: begin
                    if (fallTick) begin
                        cmdOut <= shiftReg[sdPkg::CmdFrameBits-1];
                        cmdOutEn <= 1'b1;
                        bitCnt <= bitCnt + 1'b1;
                        if (bitCnt == sdPkg::bitCntT'(sdPkg::CmdBits - 1)) begin
                            state <= sdPkg::SendCrc;
                        end
                    end
                end
                sdPkg::SendCrc: begin
                    // CRC register drains MSB first
                    if (fallTick) begin
                        cmdOut <= crcMsb;
                        bitCnt <= bitCnt + 1'b1;
                        if (bitCnt == sdPkg::bitCntT'(sdPkg::CmdFrameBits - 2)) begin
                            state <= sdPkg::SendEnd;
                        end
                    end
                end
                sdPkg::SendEnd: begin
                    if (fallTick) begin
                        if (bitCnt == sdPkg::bitCntT'(sdPkg::CmdFrameBits - 1)) begin
                            cmdOut <= shiftReg[sdPkg::CmdFrameBits-1];
                            bitCnt <= bitCnt + 1'b1;
                        end else begin
                            // End bit held a full period, release the line
                            cmdOut <= 1'b1;
                            cmdOutEn <= 1'b0;
                            link.sendDone <= 1'b1;
                            state <= sdPkg::SendIdle;
                        end
                    end
                end
                default: state <= sdPkg::SendIdle;
            endcase
        end
    end

    // Low bits preload the end bit; CRC slots are taken from the CRC register
    always_ff @(posedge clk_fast) begin
        if ((state == sdPkg::SendIdle) && link.sendStart) begin
            shiftReg <= {link.cmdBits, {(sdPkg::CmdFrameBits - sdPkg::CmdBits - 1){1'b0}}, 1'b1};
        end else if (fallTick && (state != sdPkg::SendIdle)) begin
            shiftReg <= {shiftReg[sdPkg::CmdFrameBits-2:0], 1'b0};
        end
    end

    crc7 crcGen (
        .clk_fast (clk_fast),
        .rst      (rst),
        .clear    (crcClear),
        .enable   (crcEnable),
        .shiftOut (crcShiftOut),
        .dataIn   (shiftReg[sdPkg::CmdFrameBits-1]),
        .crcOut   (),
        .crcMsb   (crcMsb)
    );

endmodule

// ==== source/crc7.sv ====
`timescale 1ns/1ps

module crc7 (
    input  logic          clk_fast,
    input  logic          rst,
    input  logic          clear,
    input  logic          enable,
    input  logic          shiftOut,
    input  logic          dataIn,
    output sdPkg::crc7T   crcOut,
    output logic          crcMsb
);

    logic feedback;

    assign feedback = dataIn ^ crcOut[6];
    assign crcMsb = crcOut[6];

    // x^7 + x^3 + 1, taps land on bits 3 and 0
    always_ff @(posedge clk_fast) begin
        if (rst || clear) begin
            crcOut <= '0;
        end else if (enable) begin
            if (shiftOut) begin
                crcOut <= {crcOut[5:0], 1'b0};
            end else begin
                crcOut <= {crcOut[5:0], 1'b0} ^ (feedback ? 7'h09 : 7'h00);
            end
        end
    end

endmodule

// ==== source/hostSequencer.sv ====
`timescale 1ns/1ps

module hostSequencer (
    input  logic              clk_fast,
    input  logic              rst,
    input  logic              cmdReq,
    input  sdPkg::cmdBitsT    cmdBits,
    input  sdPkg::respTypeT   respType,
    output logic              cmdAck,
    sdLinkIf.seq              link
);

    sdPkg::seqStateT state;

    // Engine busy windows from start pulse to done pulse
    logic sendPending;
    logic recvPending;

    // ======================================================================
    // Host handshake and engine sequencing
    // ======================================================================
    always_ff @(posedge clk_fast) begin
        if (rst) begin
            state <= sdPkg::SeqIdle;
            cmdAck <= 1'b0;
            link.sendStart <= 1'b0;
            link.recvStart <= 1'b0;
        end else begin
            link.sendStart <= 1'b0;
            link.recvStart <= 1'b0;
            case (state)
                sdPkg::SeqIdle: begin
                    if (cmdReq) begin
                        link.sendStart <= 1'b1;
                        state <= sdPkg::SeqSend;
                    end
                end
                sdPkg::SeqSend: begin
                    if (link.sendDone) begin
                        if (link.respType == sdPkg::RespNone) begin
                            cmdAck <= 1'b1;
                            state <= sdPkg::SeqAck;
                        end else begin
                            link.recvStart <= 1'b1;
                            state <= sdPkg::SeqRecv;
                        end
                    end
                end
                sdPkg::SeqRecv: begin
                    if (link.recvDone) begin
                        cmdAck <= 1'b1;
                        state <= sdPkg::SeqAck;
                    end
                end
                sdPkg::SeqAck: begin
                    // Hold ack and result until the host lets go
                    if (!cmdReq) begin
                        cmdAck <= 1'b0;
                        state <= sdPkg::SeqIdle;
                    end
                end
                default: state <= sdPkg::SeqIdle;
            endcase
        end
    end

    // Request payload captured on acceptance
    always_ff @(posedge clk_fast) begin
        if ((state == sdPkg::SeqIdle) && cmdReq) begin
            link.cmdBits <= cmdBits;
            link.respType <= respType;
        end
    end

    always_ff @(posedge clk_fast) begin
        if (rst) begin
            sendPending <= 1'b0;
            recvPending <= 1'b0;
        end else begin
            if (link.sendStart) begin
                sendPending <= 1'b1;
            end else if (link.sendDone) begin
                sendPending <= 1'b0;
            end
            if (link.recvStart) begin
                recvPending <= 1'b1;
            end else if (link.recvDone) begin
                recvPending <= 1'b0;
            end
        end
    end

    ackNeedsReq: assert property (@(posedge clk_fast) disable iff (rst)
        $rose(cmdAck) |-> cmdReq);

    startOnlyWhenIdle: assert property (@(posedge clk_fast) disable iff (rst)
        (link.sendStart || link.recvStart) |-> !(sendPending || recvPending));

endmodule

// ==== source/respReceiver.sv ====
`timescale 1ns/1ps

module respReceiver (
    input  logic        clk_fast,
    input  logic        rst,
    input  logic        riseTick,
    input  logic        cmdIn,
    sdLinkIf.receiver   link
);

    sdPkg::recvStateT state;
    sdPkg::bitCntT bitCnt;
    sdPkg::bitCntT bitNum;
    sdPkg::bitCntT lastBit;
    sdPkg::bitCntT crcFirst;
    sdPkg::bitCntT crcLast;
    sdPkg::respDataT shiftReg;
    sdPkg::crc7T crcOut;
    logic crcEnable;
    logic takeBit;

    // Bits count from 1, the start bit being bit 1
    assign bitNum = bitCnt + 1'b1;
    assign lastBit = (link.respType == sdPkg::Resp136) ?
        sdPkg::bitCntT'(sdPkg::RespBitsLong) : sdPkg::bitCntT'(sdPkg::RespBitsShort);

    // Start bit is zero, so leaving it out keeps the CRC unchanged
    assign crcFirst = (link.respType == sdPkg::Resp136) ?
        sdPkg::bitCntT'(sdPkg::Resp136CrcSkip + 1) : sdPkg::bitCntT'(2);
    assign crcLast = lastBit - sdPkg::bitCntT'($bits(sdPkg::crc7T) + 1);

    assign crcEnable = riseTick && (state == sdPkg::RecvBits) &&
        (bitNum >= crcFirst) && (bitNum <= crcLast);
    assign takeBit = riseTick &&
        (((state == sdPkg::RecvWaitStart) && !cmdIn) || (state == sdPkg::RecvBits));

    // ======================================================================
    // Response FSM, one bit per riseTick
    // ======================================================================
    always_ff @(posedge clk_fast) begin
        if (rst) begin
            state <= sdPkg::RecvIdle;
            bitCnt <= '0;
            link.recvDone <= 1'b0;
            link.respData <= '0;
            link.respCrcErr <= 1'b0;
        end else begin
            link.recvDone <= 1'b0;
            if (link.sendStart) begin
                link.respData <= '0;
                link.respCrcErr <= 1'b0;
            end
            case (state)
                sdPkg::RecvIdle: begin
                    if (link.recvStart) begin
                        bitCnt <= '0;
                        state <= sdPkg::RecvWaitStart;
                    end
                end
                sdPkg::RecvWaitStart: begin
                    if (riseTick && !cmdIn) begin
                        bitCnt <= sdPkg::bitCntT'(1);
                        state <= sdPkg::RecvBits;
                    end
                end
                sdPkg::RecvBits: begin
                    if (riseTick) begin
                        bitCnt <= bitNum;
                        if (bitNum == lastBit) begin
                            // Low register bits hold the 7 received CRC bits here
                            link.respData <= {shiftReg[sdPkg::RespBitsLong-2:0], cmdIn};
                            link.respCrcErr <= (crcOut != shiftReg[$bits(sdPkg::crc7T)-1:0]) ||
                                !cmdIn;
                            link.recvDone <= 1'b1;
                            state <= sdPkg::RecvIdle;
                        end
                    end
                end
                default: state <= sdPkg::RecvIdle;
            endcase
        end
    end

    always_ff @(posedge clk_fast) begin
        if (link.recvStart) begin
            shiftReg <= '0;
        end else if (takeBit) begin
            shiftReg <= {shiftReg[sdPkg::RespBitsLong-2:0], cmdIn};
        end
    end

    crc7 crcCheck (
        .clk_fast (clk_fast),
        .rst      (rst),
        .clear    (link.recvStart),
        .enable   (crcEnable),
        .shiftOut (1'b0),
        .dataIn   (cmdIn),
        .crcOut   (crcOut),
        .crcMsb   ()
    );

    // CMD line must already be released by the sender
    noRecvWhileDriving: assert property (@(posedge clk_fast) disable iff (rst)
        (state != sdPkg::RecvIdle) |-> !link.sendBusy);

endmodule

// ==== source/sdClockGen.sv ====
`timescale 1ns/1ps

module sdClockGen (
    input  logic clk_fast,
    input  logic rst,
    output logic sdClk,
    output logic fallTick,
    output logic riseTick
);

    sdPkg::sdClkCntT divCnt;

    // Strobes sit on the cycle just before each sdClk edge
    assign fallTick = (divCnt == sdPkg::sdClkCntT'(sdPkg::SdClkDiv - 1));
    assign riseTick = (divCnt == sdPkg::sdClkCntT'(sdPkg::SdClkDiv / 2 - 1));

    always_ff @(posedge clk_fast) begin
        if (rst) begin
            divCnt <= '0;
            sdClk <= 1'b0;
        end else begin
            divCnt <= fallTick ? '0 : divCnt + 1'b1;
            if (riseTick) begin
                sdClk <= 1'b1;
            end else if (fallTick) begin
                sdClk <= 1'b0;
            end
        end
    end

    // Each strobe comes in the opposite sdClk phase so the two never coincide
    strobesMatchPhase: assert property (@(posedge clk_fast) disable iff (rst)
        (!fallTick || sdClk) && (!riseTick || !sdClk));

endmodule

// ==== source/sdCmdHost.sv ====
`timescale 1ns/1ps

module sdCmdHost (
    input  logic              clk_fast,
    input  logic              rst,

    // Host command port
    input  logic              cmdReq,
    input  sdPkg::cmdBitsT    cmdBits,
    input  sdPkg::respTypeT   respType,
    output logic              cmdAck,
    output sdPkg::respDataT   respData,
    output logic              respCrcErr,

    // Card side
    output logic              sdClk,
    output logic              cmdOut,
    output logic              cmdOutEn,
    input  logic              cmdIn
);

    logic fallTick;
    logic riseTick;

    sdLinkIf link ();

    assign respData = link.respData;
    assign respCrcErr = link.respCrcErr;

    sdClockGen clockGen (
        .clk_fast (clk_fast),
        .rst      (rst),
        .sdClk    (sdClk),
        .fallTick (fallTick),
        .riseTick (riseTick)
    );

    hostSequencer sequencer (
        .clk_fast (clk_fast),
        .rst      (rst),
        .cmdReq   (cmdReq),
        .cmdBits  (cmdBits),
        .respType (respType),
        .cmdAck   (cmdAck),
        .link     (link.seq)
    );

    cmdSender sender (
        .clk_fast (clk_fast),
        .rst      (rst),
        .fallTick (fallTick),
        .cmdOut   (cmdOut),
        .cmdOutEn (cmdOutEn),
        .link     (link.sender)
    );

    respReceiver receiver (
        .clk_fast (clk_fast),
        .rst      (rst),
        .riseTick (riseTick),
        .cmdIn    (cmdIn),
        .link     (link.receiver)
    );

endmodule

// ==== source/sdLinkIf.sv ====
`timescale 1ns/1ps

interface sdLinkIf;

    // One-cycle start and done pulses
    logic sendStart;
    logic sendDone;
    logic recvStart;
    logic recvDone;

    // High while the sender owns the CMD line
    logic sendBusy;

    sdPkg::cmdBitsT cmdBits;
    sdPkg::respTypeT respType;
    sdPkg::respDataT respData;
    logic respCrcErr;

    modport seq (
        output sendStart, recvStart, cmdBits, respType,
        input sendDone, recvDone
    );

    modport sender (
        input sendStart, cmdBits,
        output sendDone, sendBusy
    );

    // Receiver also sees sendStart so stale results are cleared per command
    modport receiver (
        input sendStart, recvStart, respType, sendBusy,
        output recvDone, respData, respCrcErr
    );

endinterface

// ==== source/sdPkg.sv ====
package sdPkg;

    // ======================================================================
    // Frame geometry
    // ======================================================================
    localparam int CmdBits = 40;
    localparam int CmdFrameBits = 48;
    localparam int RespBitsShort = 48;
    localparam int RespBitsLong = 136;

    // R2 leaves start, direction and reserved bits out of the CRC
    localparam int Resp136CrcSkip = 8;

    // clk_fast cycles per sdClk period, low half first
    localparam int SdClkDiv = 4;
    localparam int SdClkCntBits = $clog2(SdClkDiv);
    localparam int BitCntBits = $clog2(RespBitsLong + 1);

    typedef logic [CmdBits-1:0] cmdBitsT;
    typedef logic [RespBitsLong-1:0] respDataT;
    typedef logic [6:0] crc7T;
    typedef logic [SdClkCntBits-1:0] sdClkCntT;
    typedef logic [BitCntBits-1:0] bitCntT;

    typedef enum logic [1:0] {
        RespNone = 2'd0,
        Resp48 = 2'd1,
        Resp136 = 2'd2
    } respTypeT;

    // ======================================================================
    // Engine state machines
    // ======================================================================
    typedef enum logic [1:0] {SendIdle, SendCmd, SendCrc, SendEnd} sendStateT;
    typedef enum logic [1:0] {RecvIdle, RecvWaitStart, RecvBits} recvStateT;
    typedef enum logic [1:0] {SeqIdle, SeqSend, SeqRecv, SeqAck} seqStateT;

endpackage

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
    output logic clk_fast,
    output logic rst
);

    // 20 ns period
    initial begin
        clk_fast = 1'b0;
        forever #10 clk_fast = ~clk_fast;
    end

    // Reset held for 16 rising edges
    initial begin
        rst <= 1'b1;
        repeat (16) @(posedge clk_fast);
        rst <= 1'b0;
    end

endmodule

// ==== testbench/tbSdCmdHost.sv ====
`timescale 1ns/1ps

module tbSdCmdHost;

    // Sixteen exchanges of at most about 760 cycles each
    localparam int TimeoutCycles = 60000;

    logic clk_fast;
    logic rst;
    logic cmdReq;
    sdPkg::cmdBitsT cmdBits;
    sdPkg::respTypeT respType;
    logic cmdAck;
    sdPkg::respDataT respData;
    logic respCrcErr;
    logic sdClk;
    logic cmdOut;
    logic cmdOutEn;
    logic cmdIn;

    integer seed;
    int unsigned cycleCount = 0;
    logic [47:0] capturedFrame;
    sdPkg::respDataT ackData;
    logic ackErr;
    logic [2:0] outEnHist;

    tbClock clockSource (
        .clk_fast (clk_fast),
        .rst      (rst)
    );

    sdCmdHost dut (
        .clk_fast   (clk_fast),
        .rst        (rst),
        .cmdReq     (cmdReq),
        .cmdBits    (cmdBits),
        .respType   (respType),
        .cmdAck     (cmdAck),
        .respData   (respData),
        .respCrcErr (respCrcErr),
        .sdClk      (sdClk),
        .cmdOut     (cmdOut),
        .cmdOutEn   (cmdOutEn),
        .cmdIn      (cmdIn)
    );

    always @(posedge clk_fast) begin
        cycleCount = cycleCount + 1;
        if (cycleCount == TimeoutCycles) begin
            $display("Timeout: the DUT did not finish within %0d cycles", TimeoutCycles);
            $display("TEST FAILED");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic reportMismatch(input string testName, input string what,
        input sdPkg::respDataT expected, input sdPkg::respDataT actual);
        $display("FAILED %s: %s expected %0h actual %0h", testName, what, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "Stopping at the first failed check");
    endtask

    task automatic reportProblem(input string testName, input string what);
        $display("%s: %s", testName, what);
        $display("TEST FAILED");
        $fatal(1, "Stopping at the first failed check");
    endtask

    // ======================================================================
    // Reference CRC7 and frame builders
    // ======================================================================
    function automatic sdPkg::crc7T crc7Of(input sdPkg::respDataT data, input int nBits);
        sdPkg::crc7T crc;
        logic fb;
        crc = '0;
        for (int i = nBits - 1; i >= 0; i--) begin
            fb = data[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    function automatic logic [47:0] cmdFrame(input sdPkg::cmdBitsT bits);
        return {bits, crc7Of(sdPkg::respDataT'(bits), 40), 1'b1};
    endfunction

    function automatic sdPkg::respDataT resp48Frame(input logic [5:0] index,
        input logic [31:0] arg);
        logic [39:0] body;
        body = {2'b00, index, arg};
        return sdPkg::respDataT'({body, crc7Of(sdPkg::respDataT'(body), 40), 1'b1});
    endfunction

    // Start, direction and six reserved ones lead the R2 frame
    function automatic sdPkg::respDataT resp136Frame(input logic [119:0] content);
        return {8'h3F, content, crc7Of(sdPkg::respDataT'(content), 120), 1'b1};
    endfunction

    // ======================================================================
    // Card model and host handshake
    // ======================================================================
    task automatic captureFrame(input string testName);
        do @(posedge clk_fast); while (!cmdOutEn);
        for (int i = 0; i < 48; i++) begin
            @(posedge sdClk);
            assert (cmdOutEn === 1'b1) else
                reportProblem(testName, "cmdOutEn dropped in the middle of the command frame");
            capturedFrame = {capturedFrame[46:0], cmdOut};
        end
    endtask

    task automatic sendResponse(input sdPkg::respTypeT rt, input sdPkg::respDataT frame);
        int nBits;
        nBits = (rt == sdPkg::Resp136) ? sdPkg::RespBitsLong : 48;
        // Line release plus two full periods of turnaround
        repeat (3) @(negedge sdClk);
        for (int i = nBits - 1; i >= 0; i--) begin
            @(negedge sdClk);
            @(posedge clk_fast);
            cmdIn <= frame[i];
        end
        @(negedge sdClk);
        @(posedge clk_fast);
        cmdIn <= 1'b1;
    endtask

    task automatic runCommand(input string testName, input sdPkg::cmdBitsT bits,
        input sdPkg::respTypeT rt, input sdPkg::respDataT cardFrame);
        fork
            begin
                @(posedge clk_fast);
                cmdReq <= 1'b1;
                cmdBits <= bits;
                respType <= rt;
                outEnHist = 3'b000;
                do begin
                    @(posedge clk_fast);
                    outEnHist = {outEnHist[1:0], cmdOutEn};
                end while (!cmdAck);
                ackData = respData;
                ackErr = respCrcErr;
                cmdReq <= 1'b0;
                @(posedge clk_fast);
                assert (cmdAck === 1'b1) else
                    reportMismatch(testName, "cmdAck while req drops", 1, sdPkg::respDataT'(cmdAck));
                @(posedge clk_fast);
                assert (cmdAck === 1'b0) else
                    reportMismatch(testName, "cmdAck after req low", 0, sdPkg::respDataT'(cmdAck));
            end
            begin
                captureFrame(testName);
                if (rt != sdPkg::RespNone) begin
                    sendResponse(rt, cardFrame);
                end
            end
        join
    endtask

    task automatic exchangeAndVerify(input string testName, input sdPkg::cmdBitsT bits,
        input sdPkg::respTypeT rt, input sdPkg::respDataT cardFrame, input logic expectErr);
        logic [47:0] expectedFrame;
        expectedFrame = cmdFrame(bits);
        runCommand(testName, bits, rt, cardFrame);
        assert (capturedFrame === expectedFrame) else
            reportMismatch(testName, "command frame", sdPkg::respDataT'(expectedFrame),
                sdPkg::respDataT'(capturedFrame));
        if (rt == sdPkg::RespNone) begin
            assert (outEnHist === 3'b100) else
                reportProblem(testName, "cmdAck did not rise one cycle after the frame ended");
            assert (ackData === '0) else reportMismatch(testName, "respData", '0, ackData);
        end else begin
            assert (ackData === cardFrame) else
                reportMismatch(testName, "respData", cardFrame, ackData);
        end
        assert (ackErr === expectErr) else
            reportMismatch(testName, "respCrcErr", sdPkg::respDataT'(expectErr),
                sdPkg::respDataT'(ackErr));
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic testResetState();
        logic prevClk;
        int sinceToggle;
        int toggles;
        assert (cmdAck === 1'b0) else
            reportMismatch("testResetState", "cmdAck", 0, sdPkg::respDataT'(cmdAck));
        assert (cmdOutEn === 1'b0) else
            reportMismatch("testResetState", "cmdOutEn", 0, sdPkg::respDataT'(cmdOutEn));
        assert (cmdOut === 1'b1) else
            reportMismatch("testResetState", "cmdOut", 1, sdPkg::respDataT'(cmdOut));
        assert (respCrcErr === 1'b0) else
            reportMismatch("testResetState", "respCrcErr", 0, sdPkg::respDataT'(respCrcErr));
        assert (respData === '0) else reportMismatch("testResetState", "respData", '0, respData);
        prevClk = sdClk;
        sinceToggle = 0;
        toggles = 0;
        // First interval depends on where the divider starts
        while (toggles < 6) begin
            @(posedge clk_fast);
            sinceToggle++;
            if (sdClk !== prevClk) begin
                if (toggles > 0) begin
                    assert (sinceToggle == sdPkg::SdClkDiv / 2) else
                        reportMismatch("testResetState", "sdClk half period",
                            sdPkg::respDataT'(sdPkg::SdClkDiv / 2),
                            sdPkg::respDataT'(sinceToggle));
                end
                toggles++;
                sinceToggle = 0;
                prevClk = sdClk;
            end
        end
    endtask

    task automatic testCmdFrame();
        sdPkg::cmdBitsT cmd0;
        sdPkg::cmdBitsT cmd8;
        cmd0 = {2'b01, 6'd0, 32'h0000_0000};
        cmd8 = {2'b01, 6'd8, 32'h0000_01AA};
        exchangeAndVerify("testCmdFrame", cmd0, sdPkg::RespNone, '0, 1'b0);
        // Well known CRCs of CMD0 and CMD8
        assert (capturedFrame[7:1] === 7'h4A) else
            reportMismatch("testCmdFrame", "CMD0 CRC", 'h4A, sdPkg::respDataT'(capturedFrame[7:1]));
        exchangeAndVerify("testCmdFrame", cmd8, sdPkg::RespNone, '0, 1'b0);
        assert (capturedFrame[7:1] === 7'h43) else
            reportMismatch("testCmdFrame", "CMD8 CRC", 'h43, sdPkg::respDataT'(capturedFrame[7:1]));
    endtask

    task automatic testResp48();
        exchangeAndVerify("testResp48", {2'b01, 6'd55, 32'h0}, sdPkg::Resp48,
            resp48Frame(6'd55, 32'h0000_0120), 1'b0);
    endtask

    task automatic testResp136();
        exchangeAndVerify("testResp136", {2'b01, 6'd2, 32'h0}, sdPkg::Resp136,
            resp136Frame(120'h03_5344_5355_3136_4780_1234_5678_0123), 1'b0);
    endtask

    task automatic testBadCrc();
        sdPkg::respDataT good;
        sdPkg::respDataT noEnd;
        good = resp48Frame(6'd17, 32'h0000_0900);
        noEnd = good;
        noEnd[0] = 1'b0;
        exchangeAndVerify("testBadCrc", {2'b01, 6'd17, 32'h0000_0900}, sdPkg::Resp48,
            good ^ sdPkg::respDataT'(2), 1'b1);
        exchangeAndVerify("testBadCrc", {2'b01, 6'd17, 32'h0000_0900}, sdPkg::Resp48,
            noEnd, 1'b1);
    endtask

    task automatic testRandomArgs();
        sdPkg::respTypeT rt;
        logic [31:0] rnd;
        logic [31:0] arg;
        logic [127:0] wide;
        sdPkg::respDataT frame;
        for (int i = 0; i < 10; i++) begin
            case (i % 3)
                0: rt = sdPkg::RespNone;
                1: rt = sdPkg::Resp48;
                default: rt = sdPkg::Resp136;
            endcase
            rnd = $random(seed);
            arg = $random(seed);
            wide = {$random(seed), $random(seed), $random(seed), $random(seed)};
            if (rt == sdPkg::Resp136) begin
                frame = resp136Frame(wide[119:0]);
            end else if (rt == sdPkg::Resp48) begin
                frame = resp48Frame(rnd[5:0], wide[31:0]);
            end else begin
                frame = '0;
            end
            exchangeAndVerify("testRandomArgs", {2'b01, rnd[5:0], arg}, rt, frame, 1'b0);
        end
    endtask

    initial begin
        seed = 32'h9e50;
        cmdReq <= 1'b0;
        cmdBits <= '0;
        respType <= sdPkg::RespNone;
        cmdIn <= 1'b1;
        do @(posedge clk_fast); while (rst);
        testResetState();
        testCmdFrame();
        testResp48();
        testResp136();
        testBadCrc();
        testRandomArgs();
        $display("TEST OK");
        $finish;
    end

endmodule
